// File: rtl/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

`define ADDR_WIDTH    16
`define DATA_WIDTH    32
`define ID_WIDTH      4

// One word per line, so the tag is everything above the index
`define INDEX_BITS    4
`define TAG_WIDTH     (`ADDR_WIDTH - `INDEX_BITS)

// Queue depth and reset value of every credit counter
`define CREDIT_DEPTH  4
`define PTR_WIDTH     2
`define CNT_WIDTH     3

`define SEQ_WIDTH     4

`endif

// File: rtl/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // Child side opcode
    typedef enum logic [1:0] {
        OP_READ,
        OP_WRITE,
        OP_INVALIDATE
    } cache_op_e;

    typedef enum logic {
        PARENT_READ,
        PARENT_WRITE
    } parent_op_e;

    // Decode holds at most one request waiting for a path credit
    typedef enum logic {
        DEC_IDLE,
        DEC_ISSUE
    } decode_state_e;

endpackage

`default_nettype wire

// File: rtl/cache_decode.sv
`timescale 1ns/1ps
`include "cache_macros.svh"
`default_nettype none

module cache_decode (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire logic                   child_req_valid,
    input  wire cache_pkg::cache_op_e   child_req_op,
    input  wire logic [`ADDR_WIDTH-1:0] child_req_addr,
    input  wire logic [`DATA_WIDTH-1:0] child_req_data,
    input  wire logic [`ID_WIDTH-1:0]   child_req_id,
    input  wire logic                   local_credit,
    input  wire logic                   byp_credit,
    output logic                        child_req_credit,
    output logic                        local_valid,
    output cache_pkg::cache_op_e        local_op,
    output logic [`ADDR_WIDTH-1:0]      local_addr,
    output logic [`DATA_WIDTH-1:0]      local_data,
    output logic [`ID_WIDTH-1:0]        local_id,
    output logic [`SEQ_WIDTH-1:0]       local_seq,
    output logic                        byp_valid,
    output cache_pkg::cache_op_e        byp_op,
    output logic [`ADDR_WIDTH-1:0]      byp_addr,
    output logic [`ID_WIDTH-1:0]        byp_id,
    output logic [`SEQ_WIDTH-1:0]       byp_seq,
    output logic                        byp_send_parent
);
    import cache_pkg::*;

    localparam int LINES = 1 << `INDEX_BITS;
    localparam int PTR_W = `PTR_WIDTH;
    localparam int CNT_W = `CNT_WIDTH;
    localparam int SEQ_W = `SEQ_WIDTH;

    cache_op_e              q_op   [`CREDIT_DEPTH];
    logic [`ADDR_WIDTH-1:0] q_addr [`CREDIT_DEPTH];
    logic [`DATA_WIDTH-1:0] q_data [`CREDIT_DEPTH];
    logic [`ID_WIDTH-1:0]   q_id   [`CREDIT_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       q_count;

    logic [LINES-1:0]       line_valid;
    logic [`TAG_WIDTH-1:0]  line_tag [LINES];

    decode_state_e          state;
    cache_op_e              cur_op;
    logic [`ADDR_WIDTH-1:0] cur_addr;
    logic [`DATA_WIDTH-1:0] cur_data;
    logic [`ID_WIDTH-1:0]   cur_id;
    logic [SEQ_W-1:0]       seq;
    logic [CNT_W-1:0]       local_cnt;
    logic [CNT_W-1:0]       byp_cnt;

    logic [`INDEX_BITS-1:0] cur_index;
    logic                   hit;
    logic                   to_local;
    logic                   issue;
    logic                   take;

    assign cur_index = cur_addr[`INDEX_BITS-1:0];
    assign hit = line_valid[cur_index]
              && (line_tag[cur_index] == cur_addr[`ADDR_WIDTH-1:`INDEX_BITS]);

    // Writes go through the array even on a miss, they allocate
    assign to_local = (cur_op == OP_WRITE) || (cur_op == OP_READ && hit);
    assign issue = (state == DEC_ISSUE) && (to_local ? (local_cnt != '0) : (byp_cnt != '0));
    assign take = (q_count != '0) && (state == DEC_IDLE || issue);

    assign child_req_credit = take;
    assign local_valid = issue && to_local;
    assign local_op = cur_op;
    assign local_addr = cur_addr;
    assign local_data = cur_data;
    assign local_id = cur_id;
    assign local_seq = seq;
    assign byp_valid = issue && !to_local;
    assign byp_op = cur_op;
    assign byp_addr = cur_addr;
    assign byp_id = cur_id;
    assign byp_seq = seq;
    // Read miss goes to the parent, invalidate is acknowledged to the child
    assign byp_send_parent = (cur_op == OP_READ);

    always_ff @(posedge clk) begin
        if (child_req_valid) begin
            q_op[wr_ptr] <= child_req_op;
            q_addr[wr_ptr] <= child_req_addr;
            q_data[wr_ptr] <= child_req_data;
            q_id[wr_ptr] <= child_req_id;
        end
        if (take) begin
            cur_op <= q_op[rd_ptr];
            cur_addr <= q_addr[rd_ptr];
            cur_data <= q_data[rd_ptr];
            cur_id <= q_id[rd_ptr];
        end
        if (issue && cur_op == OP_WRITE) begin
            line_tag[cur_index] <= cur_addr[`ADDR_WIDTH-1:`INDEX_BITS];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            q_count <= '0;
            state <= DEC_IDLE;
            seq <= '0;
            local_cnt <= CNT_W'(`CREDIT_DEPTH);
            byp_cnt <= CNT_W'(`CREDIT_DEPTH);
            line_valid <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(child_req_valid);
            rd_ptr <= rd_ptr + PTR_W'(take);
            q_count <= q_count + CNT_W'(child_req_valid) - CNT_W'(take);
            if (take) begin
                state <= DEC_ISSUE;
            end else if (issue) begin
                state <= DEC_IDLE;
            end
            if (issue) begin
                seq <= seq + SEQ_W'(1);
                if (cur_op == OP_WRITE) begin
                    line_valid[cur_index] <= 1'b1;
                end else if (cur_op == OP_INVALIDATE) begin
                    line_valid[cur_index] <= 1'b0;
                end
            end
            local_cnt <= local_cnt + CNT_W'(local_credit) - CNT_W'(local_valid);
            byp_cnt <= byp_cnt + CNT_W'(byp_credit) - CNT_W'(byp_valid);
        end
    end

endmodule

`default_nettype wire

// File: rtl/cache_data_array.sv
`timescale 1ns/1ps
`include "cache_macros.svh"
`default_nettype none

module cache_data_array (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire logic                   local_valid,
    input  wire cache_pkg::cache_op_e   local_op,
    input  wire logic [`ADDR_WIDTH-1:0] local_addr,
    input  wire logic [`DATA_WIDTH-1:0] local_data,
    input  wire logic [`ID_WIDTH-1:0]   local_id,
    input  wire logic [`SEQ_WIDTH-1:0]  local_seq,
    input  wire logic                   pop,
    output logic                        local_credit,
    output logic                        head_valid,
    output cache_pkg::cache_op_e        head_op,
    output logic [`ADDR_WIDTH-1:0]      head_addr,
    output logic [`DATA_WIDTH-1:0]      head_data,
    output logic [`ID_WIDTH-1:0]        head_id,
    output logic [`SEQ_WIDTH-1:0]       head_seq,
    output logic                        head_send_parent
);
    import cache_pkg::*;

    localparam int LINES = 1 << `INDEX_BITS;
    localparam int PTR_W = `PTR_WIDTH;
    localparam int CNT_W = `CNT_WIDTH;

    logic [`DATA_WIDTH-1:0] mem [LINES];

    cache_op_e              q_op     [`CREDIT_DEPTH];
    logic [`ADDR_WIDTH-1:0] q_addr   [`CREDIT_DEPTH];
    logic [`DATA_WIDTH-1:0] q_data   [`CREDIT_DEPTH];
    logic [`ID_WIDTH-1:0]   q_id     [`CREDIT_DEPTH];
    logic [`SEQ_WIDTH-1:0]  q_seq    [`CREDIT_DEPTH];
    logic                   q_parent [`CREDIT_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       count;

    logic [`INDEX_BITS-1:0] index;
    logic [`DATA_WIDTH-1:0] result;

    assign index = local_addr[`INDEX_BITS-1:0];
    // A write echoes its own data for the write-through
    assign result = (local_op == OP_WRITE) ? local_data : mem[index];

    always_ff @(posedge clk) begin
        if (local_valid) begin
            if (local_op == OP_WRITE) begin
                mem[index] <= local_data;
            end
            q_op[wr_ptr] <= local_op;
            q_addr[wr_ptr] <= local_addr;
            q_data[wr_ptr] <= result;
            q_id[wr_ptr] <= local_id;
            q_seq[wr_ptr] <= local_seq;
            q_parent[wr_ptr] <= (local_op == OP_WRITE);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(local_valid);
            rd_ptr <= rd_ptr + PTR_W'(pop);
            count <= count + CNT_W'(local_valid) - CNT_W'(pop);
        end
    end

    assign local_credit = pop;
    assign head_valid = (count != '0);
    assign head_op = q_op[rd_ptr];
    assign head_addr = q_addr[rd_ptr];
    assign head_data = q_data[rd_ptr];
    assign head_id = q_id[rd_ptr];
    assign head_seq = q_seq[rd_ptr];
    assign head_send_parent = q_parent[rd_ptr];

endmodule

`default_nettype wire

// File: rtl/cache_bypass_queue.sv
`timescale 1ns/1ps
`include "cache_macros.svh"
`default_nettype none

module cache_bypass_queue (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire logic                   byp_valid,
    input  wire cache_pkg::cache_op_e   byp_op,
    input  wire logic [`ADDR_WIDTH-1:0] byp_addr,
    input  wire logic [`ID_WIDTH-1:0]   byp_id,
    input  wire logic [`SEQ_WIDTH-1:0]  byp_seq,
    input  wire logic                   byp_send_parent,
    input  wire logic                   pop,
    output logic                        byp_credit,
    output logic                        head_valid,
    output cache_pkg::cache_op_e        head_op,
    output logic [`ADDR_WIDTH-1:0]      head_addr,
    output logic [`ID_WIDTH-1:0]        head_id,
    output logic [`SEQ_WIDTH-1:0]       head_seq,
    output logic                        head_send_parent
);
    import cache_pkg::*;

    localparam int PTR_W = `PTR_WIDTH;
    localparam int CNT_W = `CNT_WIDTH;

    cache_op_e              q_op     [`CREDIT_DEPTH];
    logic [`ADDR_WIDTH-1:0] q_addr   [`CREDIT_DEPTH];
    logic [`ID_WIDTH-1:0]   q_id     [`CREDIT_DEPTH];
    logic [`SEQ_WIDTH-1:0]  q_seq    [`CREDIT_DEPTH];
    logic                   q_parent [`CREDIT_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       count;

    always_ff @(posedge clk) begin
        if (byp_valid) begin
            q_op[wr_ptr] <= byp_op;
            q_addr[wr_ptr] <= byp_addr;
            q_id[wr_ptr] <= byp_id;
            q_seq[wr_ptr] <= byp_seq;
            q_parent[wr_ptr] <= byp_send_parent;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(byp_valid);
            rd_ptr <= rd_ptr + PTR_W'(pop);
            count <= count + CNT_W'(byp_valid) - CNT_W'(pop);
        end
    end

    // Freed slot goes straight back to decode as a credit
    assign byp_credit = pop;
    assign head_valid = (count != '0);
    assign head_op = q_op[rd_ptr];
    assign head_addr = q_addr[rd_ptr];
    assign head_id = q_id[rd_ptr];
    assign head_seq = q_seq[rd_ptr];
    assign head_send_parent = q_parent[rd_ptr];

endmodule

`default_nettype wire

// File: rtl/cache_encode.sv
`timescale 1ns/1ps
`include "cache_macros.svh"
`default_nettype none

module cache_encode (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire logic                   local_head_valid,
    input  wire cache_pkg::cache_op_e   local_head_op,
    input  wire logic [`ADDR_WIDTH-1:0] local_head_addr,
    input  wire logic [`DATA_WIDTH-1:0] local_head_data,
    input  wire logic [`ID_WIDTH-1:0]   local_head_id,
    input  wire logic [`SEQ_WIDTH-1:0]  local_head_seq,
    input  wire logic                   local_head_send_parent,
    input  wire logic                   byp_head_valid,
    input  wire cache_pkg::cache_op_e   byp_head_op,
    input  wire logic [`ADDR_WIDTH-1:0] byp_head_addr,
    input  wire logic [`ID_WIDTH-1:0]   byp_head_id,
    input  wire logic [`SEQ_WIDTH-1:0]  byp_head_seq,
    input  wire logic                   byp_head_send_parent,
    input  wire logic                   child_resp_credit,
    input  wire logic                   parent_req_credit,
    output logic                        local_pop,
    output logic                        byp_pop,
    output logic                        child_resp_valid,
    output cache_pkg::cache_op_e        child_resp_op,
    output logic [`ADDR_WIDTH-1:0]      child_resp_addr,
    output logic [`DATA_WIDTH-1:0]      child_resp_data,
    output logic [`ID_WIDTH-1:0]        child_resp_id,
    output logic                        parent_req_valid,
    output cache_pkg::parent_op_e       parent_req_op,
    output logic [`ADDR_WIDTH-1:0]      parent_req_addr,
    output logic [`DATA_WIDTH-1:0]      parent_req_data
);
    import cache_pkg::*;

    localparam int CNT_W = `CNT_WIDTH;
    localparam int SEQ_W = `SEQ_WIDTH;

    logic [SEQ_W-1:0] exp_seq;
    logic [CNT_W-1:0] child_cnt;
    logic [CNT_W-1:0] parent_cnt;

    logic byp_match;
    logic local_match;
    logic sel_parent;
    logic out_ok;
    logic send_child;
    logic send_parent;

    // Bypass head is checked first, only one head can carry exp_seq
    assign byp_match = byp_head_valid && (byp_head_seq == exp_seq);
    assign local_match = local_head_valid && (local_head_seq == exp_seq);
    assign sel_parent = byp_match ? byp_head_send_parent : local_head_send_parent;
    assign out_ok = sel_parent ? (parent_cnt != '0) : (child_cnt != '0);

    assign byp_pop = byp_match && out_ok;
    assign local_pop = !byp_match && local_match && out_ok;
    assign send_child = (byp_pop || local_pop) && !sel_parent;
    assign send_parent = (byp_pop || local_pop) && sel_parent;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_seq <= '0;
            child_cnt <= CNT_W'(`CREDIT_DEPTH);
            parent_cnt <= CNT_W'(`CREDIT_DEPTH);
            child_resp_valid <= 1'b0;
            parent_req_valid <= 1'b0;
        end else begin
            exp_seq <= exp_seq + SEQ_W'(send_child || send_parent);
            child_cnt <= child_cnt + CNT_W'(child_resp_credit) - CNT_W'(send_child);
            parent_cnt <= parent_cnt + CNT_W'(parent_req_credit) - CNT_W'(send_parent);
            child_resp_valid <= send_child;
            parent_req_valid <= send_parent;
        end
    end

    always_ff @(posedge clk) begin
        if (send_child) begin
            child_resp_op <= byp_match ? byp_head_op : local_head_op;
            child_resp_addr <= byp_match ? byp_head_addr : local_head_addr;
            // Invalidate acknowledge carries no data
            child_resp_data <= byp_match ? '0 : local_head_data;
            child_resp_id <= byp_match ? byp_head_id : local_head_id;
        end
        if (send_parent) begin
            // Bypass means read miss, local means write-through
            parent_req_op <= byp_match ? PARENT_READ : PARENT_WRITE;
            parent_req_addr <= byp_match ? byp_head_addr : local_head_addr;
            parent_req_data <= byp_match ? '0 : local_head_data;
        end
    end

endmodule

`default_nettype wire

// File: rtl/cache_top.sv
`timescale 1ns/1ps
`include "cache_macros.svh"
`default_nettype none

module cache_top (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire logic                   child_req_valid,
    input  wire cache_pkg::cache_op_e   child_req_op,
    input  wire logic [`ADDR_WIDTH-1:0] child_req_addr,
    input  wire logic [`DATA_WIDTH-1:0] child_req_data,
    input  wire logic [`ID_WIDTH-1:0]   child_req_id,
    output logic                        child_req_credit,
    output logic                        child_resp_valid,
    output cache_pkg::cache_op_e        child_resp_op,
    output logic [`ADDR_WIDTH-1:0]      child_resp_addr,
    output logic [`DATA_WIDTH-1:0]      child_resp_data,
    output logic [`ID_WIDTH-1:0]        child_resp_id,
    input  wire logic                   child_resp_credit,
    output logic                        parent_req_valid,
    output cache_pkg::parent_op_e       parent_req_op,
    output logic [`ADDR_WIDTH-1:0]      parent_req_addr,
    output logic [`DATA_WIDTH-1:0]      parent_req_data,
    input  wire logic                   parent_req_credit
);
    import cache_pkg::*;

    // Decode to array and bypass queue
    logic                   local_valid;
    cache_op_e              local_op;
    logic [`ADDR_WIDTH-1:0] local_addr;
    logic [`DATA_WIDTH-1:0] local_data;
    logic [`ID_WIDTH-1:0]   local_id;
    logic [`SEQ_WIDTH-1:0]  local_seq;
    logic                   local_credit;
    logic                   byp_valid;
    cache_op_e              byp_op;
    logic [`ADDR_WIDTH-1:0] byp_addr;
    logic [`ID_WIDTH-1:0]   byp_id;
    logic [`SEQ_WIDTH-1:0]  byp_seq;
    logic                   byp_send_parent;
    logic                   byp_credit;

    // Queue heads into encode
    logic                   local_head_valid;
    cache_op_e              local_head_op;
    logic [`ADDR_WIDTH-1:0] local_head_addr;
    logic [`DATA_WIDTH-1:0] local_head_data;
    logic [`ID_WIDTH-1:0]   local_head_id;
    logic [`SEQ_WIDTH-1:0]  local_head_seq;
    logic                   local_head_send_parent;
    logic                   local_pop;
    logic                   byp_head_valid;
    cache_op_e              byp_head_op;
    logic [`ADDR_WIDTH-1:0] byp_head_addr;
    logic [`ID_WIDTH-1:0]   byp_head_id;
    logic [`SEQ_WIDTH-1:0]  byp_head_seq;
    logic                   byp_head_send_parent;
    logic                   byp_pop;

    cache_decode decode_inst (
        .clk, .arst_n,
        .child_req_valid, .child_req_op, .child_req_addr, .child_req_data, .child_req_id,
        .local_credit, .byp_credit, .child_req_credit,
        .local_valid, .local_op, .local_addr, .local_data, .local_id, .local_seq,
        .byp_valid, .byp_op, .byp_addr, .byp_id, .byp_seq, .byp_send_parent
    );

    cache_data_array data_array_inst (
        .clk, .arst_n,
        .local_valid, .local_op, .local_addr, .local_data, .local_id, .local_seq,
        .pop              (local_pop),
        .local_credit,
        .head_valid       (local_head_valid),
        .head_op          (local_head_op),
        .head_addr        (local_head_addr),
        .head_data        (local_head_data),
        .head_id          (local_head_id),
        .head_seq         (local_head_seq),
        .head_send_parent (local_head_send_parent)
    );

    cache_bypass_queue bypass_queue_inst (
        .clk, .arst_n,
        .byp_valid, .byp_op, .byp_addr, .byp_id, .byp_seq, .byp_send_parent,
        .pop              (byp_pop),
        .byp_credit,
        .head_valid       (byp_head_valid),
        .head_op          (byp_head_op),
        .head_addr        (byp_head_addr),
        .head_id          (byp_head_id),
        .head_seq         (byp_head_seq),
        .head_send_parent (byp_head_send_parent)
    );

    cache_encode encode_inst (
        .clk, .arst_n,
        .local_head_valid, .local_head_op, .local_head_addr, .local_head_data,
        .local_head_id, .local_head_seq, .local_head_send_parent,
        .byp_head_valid, .byp_head_op, .byp_head_addr, .byp_head_id,
        .byp_head_seq, .byp_head_send_parent,
        .child_resp_credit, .parent_req_credit,
        .local_pop, .byp_pop,
        .child_resp_valid, .child_resp_op, .child_resp_addr, .child_resp_data, .child_resp_id,
        .parent_req_valid, .parent_req_op, .parent_req_addr, .parent_req_data
    );

endmodule

`default_nettype wire

// File: tb/cache_asserts.sv
`timescale 1ns/1ps
`include "cache_macros.svh"
`default_nettype none

module cache_asserts (
    input wire logic clk,
    input wire logic arst_n,
    input wire logic child_req_valid,
    input wire logic child_req_credit,
    input wire logic child_resp_valid,
    input wire logic child_resp_credit,
    input wire logic parent_req_valid,
    input wire logic parent_req_credit
);
    int   req_out;
    int   child_out;
    int   parent_out;
    bit   reset_err = 1'b0;
    bit   req_err = 1'b0;
    bit   child_err = 1'b0;
    bit   parent_err = 1'b0;
    logic failed;

    assign failed = reset_err | req_err | child_err | parent_err;

    // Credits spent and not yet returned on each link
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_out <= 0;
            child_out <= 0;
            parent_out <= 0;
        end else begin
            req_out <= req_out + int'(child_req_valid) - int'(child_req_credit);
            child_out <= child_out + int'(child_resp_valid) - int'(child_resp_credit);
            parent_out <= parent_out + int'(parent_req_valid) - int'(parent_req_credit);
        end
    end

    reset_quiet: assert property (@(posedge clk)
        (!arst_n || $rose(arst_n)) |-> !(child_resp_valid || parent_req_valid || child_req_credit))
    else begin
        reset_err = 1'b1;
        $error("output valid or request credit high during or right after reset");
    end

    // Decode must never hand back a credit for a request it did not receive
    req_bound: assert property (@(posedge clk) disable iff (!arst_n)
        req_out + int'(child_req_valid) - int'(child_req_credit) >= 0
        && req_out + int'(child_req_valid) - int'(child_req_credit) <= `CREDIT_DEPTH)
    else begin
        req_err = 1'b1;
        $error("child requests beyond the credits granted, or credits returned for no request");
    end

    child_bound: assert property (@(posedge clk) disable iff (!arst_n)
        child_out + int'(child_resp_valid) - int'(child_resp_credit) <= `CREDIT_DEPTH)
    else begin
        child_err = 1'b1;
        $error("child responses sent beyond the credits returned");
    end

    parent_bound: assert property (@(posedge clk) disable iff (!arst_n)
        parent_out + int'(parent_req_valid) - int'(parent_req_credit) <= `CREDIT_DEPTH)
    else begin
        parent_err = 1'b1;
        $error("parent requests sent beyond the credits returned");
    end

endmodule

`default_nettype wire

// File: tb/cache_tb.sv
`timescale 1ns/1ps
`include "cache_macros.svh"
`default_nettype none

module cache_tb;
    import cache_pkg::*;

    localparam int LINES = 1 << `INDEX_BITS;
    localparam int TAG_W = `TAG_WIDTH;
    localparam int CHILD_W = $bits(cache_op_e) + `ADDR_WIDTH + `DATA_WIDTH + `ID_WIDTH;
    localparam int PARENT_W = $bits(parent_op_e) + `ADDR_WIDTH + `DATA_WIDTH;
    localparam int WAIT_LIMIT = 400;
    localparam int DRAIN_LIMIT = 2000;

    logic                   clk;
    logic                   arst_n;
    logic                   child_req_valid;
    cache_op_e              child_req_op;
    logic [`ADDR_WIDTH-1:0] child_req_addr;
    logic [`DATA_WIDTH-1:0] child_req_data;
    logic [`ID_WIDTH-1:0]   child_req_id;
    logic                   child_req_credit;
    logic                   child_resp_valid;
    cache_op_e              child_resp_op;
    logic [`ADDR_WIDTH-1:0] child_resp_addr;
    logic [`DATA_WIDTH-1:0] child_resp_data;
    logic [`ID_WIDTH-1:0]   child_resp_id;
    logic                   child_resp_credit;
    logic                   parent_req_valid;
    parent_op_e             parent_req_op;
    logic [`ADDR_WIDTH-1:0] parent_req_addr;
    logic [`DATA_WIDTH-1:0] parent_req_data;
    logic                   parent_req_credit;

    // Reference model of tag store and data array
    logic [LINES-1:0]       m_valid;
    logic [TAG_W-1:0]       m_tag [LINES];
    logic [`DATA_WIDTH-1:0] m_data [LINES];

    logic [CHILD_W-1:0]  child_q [$];
    logic [PARENT_W-1:0] parent_q [$];
    string               child_name_q [$];
    string               parent_name_q [$];
    logic [CHILD_W-1:0]  child_exp;
    logic [CHILD_W-1:0]  child_act;
    logic [PARENT_W-1:0] parent_exp;
    logic [PARENT_W-1:0] parent_act;
    string               check_name;

    int req_sent = 0;
    int req_returned = 0;
    int child_seen = 0;
    int child_returned = 0;
    int parent_seen = 0;
    int parent_returned = 0;
    int hold_left = 0;

    cache_top uut (.*);

    bind cache_top cache_asserts asserts_inst (
        .clk(clk), .arst_n(arst_n),
        .child_req_valid(child_req_valid), .child_req_credit(child_req_credit),
        .child_resp_valid(child_resp_valid), .child_resp_credit(child_resp_credit),
        .parent_req_valid(parent_req_valid), .parent_req_credit(parent_req_credit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        stop_with_error($sformatf("mismatch in %s: expected %h, actual %h",
                                  name, expected, actual));
    endtask

    task automatic predict_outputs(input string name, input cache_op_e op,
                                   input logic [`ADDR_WIDTH-1:0] addr,
                                   input logic [`DATA_WIDTH-1:0] data,
                                   input logic [`ID_WIDTH-1:0] id);
        logic [`INDEX_BITS-1:0] idx;
        logic [TAG_W-1:0]       tag;
        idx = addr[`INDEX_BITS-1:0];
        tag = addr[`ADDR_WIDTH-1:`INDEX_BITS];
        if (op == OP_READ && m_valid[idx] && m_tag[idx] == tag) begin
            child_q.push_back({OP_READ, addr, m_data[idx], id});
            child_name_q.push_back(name);
        end else if (op == OP_READ) begin
            parent_q.push_back({PARENT_READ, addr, {`DATA_WIDTH{1'b0}}});
            parent_name_q.push_back(name);
        end else if (op == OP_WRITE) begin
            m_valid[idx] = 1'b1;
            m_tag[idx] = tag;
            m_data[idx] = data;
            parent_q.push_back({PARENT_WRITE, addr, data});
            parent_name_q.push_back(name);
        end else begin
            m_valid[idx] = 1'b0;
            child_q.push_back({OP_INVALIDATE, addr, {`DATA_WIDTH{1'b0}}, id});
            child_name_q.push_back(name);
        end
    endtask

    // Called on a falling edge, returns on the next one
    task automatic send_request(input string name, input cache_op_e op,
                                input logic [`ADDR_WIDTH-1:0] addr,
                                input logic [`DATA_WIDTH-1:0] data,
                                input logic [`ID_WIDTH-1:0] id);
        int waited;
        waited = 0;
        while (req_sent >= req_returned + `CREDIT_DEPTH && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (req_sent >= req_returned + `CREDIT_DEPTH) begin
            stop_with_error("timeout waiting for a child request credit");
        end
        predict_outputs(name, op, addr, data, id);
        child_req_valid = 1'b1;
        child_req_op = op;
        child_req_addr = addr;
        child_req_data = data;
        child_req_id = id;
        req_sent++;
        @(negedge clk);
        child_req_valid = 1'b0;
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while ((child_q.size() != 0 || parent_q.size() != 0) && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (child_q.size() != 0 || parent_q.size() != 0) begin
            stop_with_error("timeout waiting for the expected outputs to arrive");
        end
    endtask

    task automatic check_child_resp();
        child_act = {child_resp_op, child_resp_addr, child_resp_data, child_resp_id};
        if (child_q.size() == 0) begin
            stop_with_error("child response arrived when none was expected");
        end else begin
            child_exp = child_q.pop_front();
            check_name = child_name_q.pop_front();
            assert (child_act == child_exp)
            else report_mismatch(check_name, 64'(child_exp), 64'(child_act));
        end
    endtask

    task automatic check_parent_req();
        parent_act = {parent_req_op, parent_req_addr, parent_req_data};
        if (parent_q.size() == 0) begin
            stop_with_error("parent request arrived when none was expected");
        end else begin
            parent_exp = parent_q.pop_front();
            check_name = parent_name_q.pop_front();
            assert (parent_act == parent_exp)
            else report_mismatch(check_name, 64'(parent_exp), 64'(parent_act));
        end
    endtask

    // Credit pulses and output valids are counted on the rising edge
    always @(posedge clk) begin
        req_returned <= req_returned + int'(child_req_credit);
        child_seen <= child_seen + int'(child_resp_valid);
        parent_seen <= parent_seen + int'(parent_req_valid);
    end

    always @(negedge clk) begin
        if (uut.asserts_inst.failed) begin
            stop_with_error("a bound assertion on credits or reset failed");
        end else begin
            if (child_resp_valid) begin
                check_child_resp();
            end
            if (parent_req_valid) begin
                check_parent_req();
            end
        end
    end

    // Output credits come back late, with long random stalls
    initial begin
        child_resp_credit = 1'b0;
        parent_req_credit = 1'b0;
        forever begin
            @(negedge clk);
            child_resp_credit = 1'b0;
            parent_req_credit = 1'b0;
            if (hold_left > 0) begin
                hold_left--;
            end else if ($urandom_range(99) < 2) begin
                hold_left = 20 + int'($urandom_range(40));
            end else begin
                if (child_seen > child_returned && $urandom_range(1) == 1) begin
                    child_resp_credit = 1'b1;
                    child_returned++;
                end
                if (parent_seen > parent_returned && $urandom_range(1) == 1) begin
                    parent_req_credit = 1'b1;
                    parent_returned++;
                end
            end
        end
    end

    initial begin
        int                     op_pick;
        cache_op_e              op;
        logic [`ADDR_WIDTH-1:0] addr;
        void'($urandom(78225));
        arst_n = 1'b0;
        child_req_valid = 1'b0;
        child_req_op = OP_READ;
        child_req_addr = '0;
        child_req_data = '0;
        child_req_id = '0;
        m_valid = '0;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        send_request("write_then_hit", OP_WRITE, 16'h0015, 32'h1234_5678, 4'd1);
        send_request("write_then_hit", OP_READ, 16'h0015, '0, 4'd2);
        wait_for_drain();

        // Never written, then an index taken over by another tag
        send_request("read_miss", OP_READ, 16'h0037, '0, 4'd3);
        send_request("read_miss", OP_WRITE, 16'h0109, 32'hcafe_0001, 4'd4);
        send_request("read_miss", OP_WRITE, 16'h0209, 32'hcafe_0002, 4'd5);
        send_request("read_miss", OP_READ, 16'h0109, '0, 4'd6);
        wait_for_drain();

        send_request("invalidate", OP_INVALIDATE, 16'h0015, '0, 4'd7);
        send_request("invalidate", OP_READ, 16'h0015, '0, 4'd8);
        wait_for_drain();

        // Few indices and tags so hits, misses and evictions mix
        for (int n = 0; n < 200; n++) begin
            op_pick = $urandom_range(3);
            op = (op_pick == 2) ? OP_WRITE : (op_pick == 3) ? OP_INVALIDATE : OP_READ;
            addr = {TAG_W'($urandom_range(2)), `INDEX_BITS'($urandom_range(3))};
            send_request("random_mix", op, addr, $urandom, `ID_WIDTH'($urandom_range(15)));
            if ($urandom_range(3) == 0) begin
                repeat ($urandom_range(5)) @(negedge clk);
            end
        end
        wait_for_drain();
        @(negedge clk);

        if (!uut.asserts_inst.failed) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            stop_with_error("a bound assertion on credits or reset failed");
        end
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+rtl
rtl/cache_pkg.sv
rtl/cache_decode.sv
rtl/cache_data_array.sv
rtl/cache_bypass_queue.sv
rtl/cache_encode.sv
rtl/cache_top.sv
tb/cache_asserts.sv
tb/cache_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module cache_tb -f all.f -o cache_tb_sim

./obj_dir/cache_tb_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
grep -q "Result: PASSED" sim.log
